/* rtl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

  // Data and instruction widths
  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;
  localparam int ilen       = 32;

  // Bit 4 selects the 32-bit word form, low nibble selects the operation
  typedef enum logic [4:0] {
    alu_add  = 5'b0_0000,
    alu_sub  = 5'b0_0001,
    alu_sll  = 5'b0_0010,
    alu_slt  = 5'b0_0011,
    alu_sltu = 5'b0_0100,
    alu_xor  = 5'b0_0101,
    alu_srl  = 5'b0_0110,
    alu_sra  = 5'b0_0111,
    alu_or   = 5'b0_1000,
    alu_and  = 5'b0_1001,
    alu_jalr = 5'b0_1010,
    alu_addw = 5'b1_0000,
    alu_subw = 5'b1_0001,
    alu_sllw = 5'b1_0010,
    alu_srlw = 5'b1_0110,
    alu_sraw = 5'b1_0111
  } alu_op_t;

  // Major opcodes
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_jalr      = 7'b1100111;

  // funct3 field
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7 field
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

endpackage

/* rtl/riscv_wb_pkg.sv */
package riscv_wb_pkg;

  // Bus widths
  localparam int wb_adr_w = 6;
  localparam int wb_dat_w = 64;

  // Width of the saturating illegal-instruction counter
  localparam int illegal_cnt_w = 8;

  // Register map of the slave port
  // Write executes the low 32 bits as an instruction
  localparam logic [wb_adr_w-1:0] adr_instr    = 6'd0;
  // Last JALR target, read only
  localparam logic [wb_adr_w-1:0] adr_target   = 6'd1;
  // Illegal count, zero-extended
  localparam logic [wb_adr_w-1:0] adr_illegal  = 6'd2;
  // x0 to x31 live at 32 to 63
  localparam logic [wb_adr_w-1:0] adr_reg_base = 6'd32;

endpackage

/* rtl/riscv_alu_if.sv */
`timescale 1ns/10ps

interface riscv_alu_if;

  riscv_isa_pkg::alu_op_t                     alu_ctrl;
  logic signed [riscv_isa_pkg::xlen-1:0]      rs1data;
  logic signed [riscv_isa_pkg::xlen-1:0]      rs2data;
  logic signed [riscv_isa_pkg::xlen-1:0]      result;

  // Decoder drives the operation only
  modport decode (
    output alu_ctrl
  );

  // Operands come from the top
  modport alu (
    input  alu_ctrl,
    input  rs1data,
    input  rs2data,
    output result
  );

endinterface

/* rtl/riscv_alu.sv */
`timescale 1ns/10ps

module riscv_alu (
  riscv_alu_if.alu i_alu
);

  logic signed [riscv_isa_pkg::xlen-1:0] op_a;
  logic signed [riscv_isa_pkg::xlen-1:0] op_b;
  logic signed [riscv_isa_pkg::xlen-1:0] sext_a;
  logic signed [riscv_isa_pkg::xlen-1:0] sra_w;
  logic        [riscv_isa_pkg::xlen-1:0] sum;
  logic        [riscv_isa_pkg::xlen-1:0] diff;
  logic        [riscv_isa_pkg::xlen-1:0] full_res;
  logic        [31:0]                    word_res;
  logic        [5:0]                     shamt;
  logic        [4:0]                     shamt_w;
  logic                                  is_word;

  assign op_a    = i_alu.rs1data;
  assign op_b    = i_alu.rs2data;
  assign is_word = i_alu.alu_ctrl[4];

  // Doubleword shifts use six bits, word shifts five
  assign shamt   = op_b[5:0];
  assign shamt_w = op_b[4:0];

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  // sraw works on the sign-extended low word
  assign sext_a = {{32{op_a[31]}}, op_a[31:0]};
  assign sra_w  = sext_a >>> shamt_w;

  always_comb begin
    full_res = sum;
    word_res = sum[31:0];
    case (i_alu.alu_ctrl[3:0])
      4'd0: begin
        full_res = sum;
        word_res = sum[31:0];
      end
      4'd1: begin
        full_res = diff;
        word_res = diff[31:0];
      end
      4'd2: begin
        full_res = op_a << shamt;
        word_res = op_a[31:0] << shamt_w;
      end
      // Signed and unsigned compares
      4'd3: full_res = {{(riscv_isa_pkg::xlen-1){1'b0}}, (op_a < op_b)};
      4'd4: full_res = {{(riscv_isa_pkg::xlen-1){1'b0}}, ($unsigned(op_a) < $unsigned(op_b))};
      4'd5: full_res = op_a ^ op_b;
      4'd6: begin
        full_res = $unsigned(op_a) >> shamt;
        word_res = op_a[31:0] >> shamt_w;
      end
      4'd7: begin
        full_res = op_a >>> shamt;
        word_res = sra_w[31:0];
      end
      4'd8: full_res = op_a | op_b;
      4'd9: full_res = op_a & op_b;
      // Jump target with bit 0 cleared
      4'd10: full_res = {sum[riscv_isa_pkg::xlen-1:1], 1'b0};
      default: begin
        full_res = sum;
        word_res = sum[31:0];
      end
    endcase

    if (is_word) begin
      i_alu.result = {{32{word_res[31]}}, word_res};
    end else begin
      i_alu.result = full_res;
    end
  end

endmodule

/* rtl/riscv_decoder.sv */
`timescale 1ns/10ps

module riscv_decoder (
  input  logic [riscv_isa_pkg::ilen-1:0]       i_instr,
  output logic [riscv_isa_pkg::reg_addr_w-1:0] o_rs1_addr,
  output logic [riscv_isa_pkg::reg_addr_w-1:0] o_rs2_addr,
  output logic [riscv_isa_pkg::reg_addr_w-1:0] o_rd_addr,
  output logic [riscv_isa_pkg::xlen-1:0]       o_imm,
  output logic                                 o_use_imm,
  output logic                                 o_wr_en,
  output logic                                 o_is_jalr,
  output logic                                 o_illegal,
  riscv_alu_if.decode                          i_alu
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic                   f7_is_base;
  logic                   f7_is_alt;
  logic                   legal;
  logic                   is_word;
  logic                   use_imm;
  logic                   jalr;
  riscv_isa_pkg::alu_op_t op;

  assign opcode     = i_instr[6:0];
  assign o_rd_addr  = i_instr[11:7];
  assign funct3     = i_instr[14:12];
  assign o_rs1_addr = i_instr[19:15];
  assign o_rs2_addr = i_instr[24:20];
  assign funct7     = i_instr[31:25];

  // I-type immediate, sign extended
  assign o_imm = {{(riscv_isa_pkg::xlen-12){i_instr[31]}}, i_instr[31:20]};

  assign f7_is_base = (funct7 == riscv_isa_pkg::f7_base);
  assign f7_is_alt  = (funct7 == riscv_isa_pkg::f7_alt);

  // Legality and instruction class
  always_comb begin
    legal   = 1'b0;
    is_word = 1'b0;
    use_imm = 1'b0;
    jalr    = 1'b0;
    case (opcode)
      riscv_isa_pkg::opc_op: begin
        legal = f7_is_base || (f7_is_alt && (funct3 == riscv_isa_pkg::f3_add_sub ||
                                             funct3 == riscv_isa_pkg::f3_srl_sra));
      end
      riscv_isa_pkg::opc_op_32: begin
        is_word = 1'b1;
        case (funct3)
          riscv_isa_pkg::f3_add_sub,
          riscv_isa_pkg::f3_srl_sra: legal = f7_is_base || f7_is_alt;
          riscv_isa_pkg::f3_sll:     legal = f7_is_base;
          default:                   legal = 1'b0;
        endcase
      end
      riscv_isa_pkg::opc_op_imm: begin
        use_imm = 1'b1;
        // 6-bit shamt leaves only funct7[6:1] to check
        case (funct3)
          riscv_isa_pkg::f3_sll:     legal = (funct7[6:1] == 6'b0);
          riscv_isa_pkg::f3_srl_sra: legal = (funct7[6:1] == 6'b0) ||
                                             (funct7[6:1] == riscv_isa_pkg::f7_alt[6:1]);
          default:                   legal = 1'b1;
        endcase
      end
      riscv_isa_pkg::opc_op_imm_32: begin
        use_imm = 1'b1;
        is_word = 1'b1;
        case (funct3)
          riscv_isa_pkg::f3_add_sub: legal = 1'b1;
          riscv_isa_pkg::f3_sll:     legal = f7_is_base;
          riscv_isa_pkg::f3_srl_sra: legal = f7_is_base || f7_is_alt;
          default:                   legal = 1'b0;
        endcase
      end
      riscv_isa_pkg::opc_jalr: begin
        use_imm = 1'b1;
        jalr    = 1'b1;
        // JALR needs funct3 of zero
        legal   = (funct3 == 3'b000);
      end
      default: legal = 1'b0;
    endcase
  end

  // ALU operation select
  always_comb begin
    op = riscv_isa_pkg::alu_add;
    case (funct3)
      riscv_isa_pkg::f3_add_sub: begin
        // Immediate forms have no subtract
        if (f7_is_alt && !use_imm) begin
          op = is_word ? riscv_isa_pkg::alu_subw : riscv_isa_pkg::alu_sub;
        end else begin
          op = is_word ? riscv_isa_pkg::alu_addw : riscv_isa_pkg::alu_add;
        end
      end
      riscv_isa_pkg::f3_sll:  op = is_word ? riscv_isa_pkg::alu_sllw : riscv_isa_pkg::alu_sll;
      riscv_isa_pkg::f3_slt:  op = riscv_isa_pkg::alu_slt;
      riscv_isa_pkg::f3_sltu: op = riscv_isa_pkg::alu_sltu;
      riscv_isa_pkg::f3_xor:  op = riscv_isa_pkg::alu_xor;
      riscv_isa_pkg::f3_srl_sra: begin
        if (funct7[5]) begin
          op = is_word ? riscv_isa_pkg::alu_sraw : riscv_isa_pkg::alu_sra;
        end else begin
          op = is_word ? riscv_isa_pkg::alu_srlw : riscv_isa_pkg::alu_srl;
        end
      end
      riscv_isa_pkg::f3_or:   op = riscv_isa_pkg::alu_or;
      riscv_isa_pkg::f3_and:  op = riscv_isa_pkg::alu_and;
      default:                op = riscv_isa_pkg::alu_add;
    endcase
    if (jalr) begin
      op = riscv_isa_pkg::alu_jalr;
    end
  end

  assign i_alu.alu_ctrl = op;
  assign o_use_imm      = use_imm;
  assign o_illegal      = !legal;
  assign o_is_jalr      = jalr && legal;
  // No link write since the unit has no PC
  assign o_wr_en        = legal && !jalr && (o_rd_addr != '0);

endmodule

/* rtl/riscv_regfile.sv */
`timescale 1ns/10ps

module riscv_regfile (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  input  logic                                 i_we,
  input  logic [riscv_isa_pkg::reg_addr_w-1:0] i_waddr,
  input  logic [riscv_isa_pkg::reg_addr_w-1:0] i_raddr1,
  input  logic [riscv_isa_pkg::reg_addr_w-1:0] i_raddr2,
  input  logic [riscv_isa_pkg::reg_addr_w-1:0] i_raddr3,
  input  logic [riscv_isa_pkg::xlen-1:0]       i_wdata,
  output logic [riscv_isa_pkg::xlen-1:0]       o_rdata1,
  output logic [riscv_isa_pkg::xlen-1:0]       o_rdata2,
  output logic [riscv_isa_pkg::xlen-1:0]       o_rdata3
);

  logic [riscv_isa_pkg::xlen-1:0] regs [0:31];

  // Entry 0 is never written
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 reads as zero on every port
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];
  // Bus read port
  assign o_rdata3 = (i_raddr3 == '0) ? '0 : regs[i_raddr3];

endmodule

/* rtl/riscv_exec_wb.sv */
`timescale 1ns/10ps

module riscv_exec_wb (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_wb_cyc,
  input  logic                              i_wb_stb,
  input  logic                              i_wb_we,
  input  logic [riscv_wb_pkg::wb_adr_w-1:0] i_wb_adr,
  input  logic [riscv_wb_pkg::wb_dat_w-1:0] i_wb_dat,
  output logic [riscv_wb_pkg::wb_dat_w-1:0] o_wb_dat,
  output logic                              o_wb_ack
);

  logic                                    req;
  logic                                    exec;
  logic [riscv_isa_pkg::reg_addr_w-1:0]    rs1_addr;
  logic [riscv_isa_pkg::reg_addr_w-1:0]    rs2_addr;
  logic [riscv_isa_pkg::reg_addr_w-1:0]    rd_addr;
  logic [riscv_isa_pkg::xlen-1:0]          imm;
  logic [riscv_isa_pkg::xlen-1:0]          rs1_val;
  logic [riscv_isa_pkg::xlen-1:0]          rs2_val;
  logic [riscv_isa_pkg::xlen-1:0]          bus_reg_val;
  logic                                    use_imm;
  logic                                    wr_en;
  logic                                    is_jalr;
  logic                                    illegal;
  logic [riscv_isa_pkg::xlen-1:0]          jump_target;
  logic [riscv_wb_pkg::illegal_cnt_w-1:0]  illegal_cnt;
  logic [riscv_wb_pkg::wb_dat_w-1:0]       rd_mux;

  riscv_alu_if alu_bus ();

  // A new access is seen only while ack is low
  assign req  = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign exec = req && i_wb_we && (i_wb_adr == riscv_wb_pkg::adr_instr);

  riscv_decoder riscv_decoder_i (
    .i_instr    (i_wb_dat[riscv_isa_pkg::ilen-1:0]),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .o_rd_addr  (rd_addr),
    .o_imm      (imm),
    .o_use_imm  (use_imm),
    .o_wr_en    (wr_en),
    .o_is_jalr  (is_jalr),
    .o_illegal  (illegal),
    .i_alu      (alu_bus)
  );

  assign alu_bus.rs1data = rs1_val;
  assign alu_bus.rs2data = use_imm ? imm : rs2_val;

  riscv_alu riscv_alu_i (
    .i_alu (alu_bus)
  );

  riscv_regfile riscv_regfile_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_we     (exec && wr_en),
    .i_waddr  (rd_addr),
    .i_raddr1 (rs1_addr),
    .i_raddr2 (rs2_addr),
    .i_raddr3 (i_wb_adr[riscv_isa_pkg::reg_addr_w-1:0]),
    .i_wdata  (alu_bus.result),
    .o_rdata1 (rs1_val),
    .o_rdata2 (rs2_val),
    .o_rdata3 (bus_reg_val)
  );

  // Read data select
  always_comb begin
    rd_mux = '0;
    if (i_wb_adr >= riscv_wb_pkg::adr_reg_base) begin
      rd_mux = bus_reg_val;
    end else if (i_wb_adr == riscv_wb_pkg::adr_target) begin
      rd_mux = jump_target;
    end else if (i_wb_adr == riscv_wb_pkg::adr_illegal) begin
      rd_mux = {{(riscv_wb_pkg::wb_dat_w-riscv_wb_pkg::illegal_cnt_w){1'b0}}, illegal_cnt};
    end
  end

  // Ack, jump target and saturating illegal count
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_ack    <= 1'b0;
      jump_target <= '0;
      illegal_cnt <= '0;
    end else begin
      o_wb_ack <= req;
      if (exec && is_jalr) begin
        jump_target <= alu_bus.result;
      end
      if (exec && illegal && (illegal_cnt != '1)) begin
        illegal_cnt <= illegal_cnt + {{(riscv_wb_pkg::illegal_cnt_w-1){1'b0}}, 1'b1};
      end
    end
  end

  // Read data is valid with ack
  always_ff @(posedge i_clk) begin
    if (req && !i_wb_we) begin
      o_wb_dat <= rd_mux;
    end
  end

endmodule

/* sim/riscv_exec_wb_sva.sv */
`timescale 1ns/10ps

module riscv_exec_wb_sva (
  input logic                              i_clk,
  input logic                              i_rst,
  input logic                              i_wb_cyc,
  input logic                              i_wb_stb,
  input logic                              i_wb_we,
  input logic [riscv_wb_pkg::wb_adr_w-1:0] i_wb_adr,
  input logic [riscv_wb_pkg::wb_dat_w-1:0] o_wb_dat,
  input logic                              o_wb_ack
);

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_ack |=> !o_wb_ack)
    else $error("ack stayed high for more than one cycle");

  // Ack follows a request seen on the previous edge
  ack_after_req: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else $error("ack raised without a preceding request");

  // x0 always reads back as zero
  x0_reads_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_wb_cyc && i_wb_stb && !i_wb_we && !o_wb_ack &&
     i_wb_adr == riscv_wb_pkg::adr_reg_base) |=> (o_wb_dat == '0))
    else $error("read of x0 returned a nonzero value");

endmodule

bind riscv_exec_wb riscv_exec_wb_sva riscv_exec_wb_sva_i (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_wb_cyc (i_wb_cyc),
  .i_wb_stb (i_wb_stb),
  .i_wb_we  (i_wb_we),
  .i_wb_adr (i_wb_adr),
  .o_wb_dat (o_wb_dat),
  .o_wb_ack (o_wb_ack)
);

/* sim/riscv_exec_wb_tb.sv */
`timescale 1ns/10ps

module riscv_exec_wb_tb;

  logic                              clk;
  logic                              rst;
  logic                              wb_cyc;
  logic                              wb_stb;
  logic                              wb_we;
  logic [riscv_wb_pkg::wb_adr_w-1:0] wb_adr;
  logic [riscv_wb_pkg::wb_dat_w-1:0] wb_wdata;
  logic [riscv_wb_pkg::wb_dat_w-1:0] wb_rdata;
  logic                              wb_ack;

  // Model state
  logic [riscv_isa_pkg::xlen-1:0]         model_regs [0:31];
  logic [riscv_isa_pkg::xlen-1:0]         model_target;
  logic [riscv_wb_pkg::illegal_cnt_w-1:0] model_illegal;
  int                                     mismatches;
  int                                     timeouts;

  // funct3 per random op: add sub sll slt sltu xor srl sra or and
  localparam logic [2:0] op_f3 [0:9] = '{3'b000, 3'b000, 3'b001, 3'b010, 3'b011,
                                         3'b100, 3'b101, 3'b101, 3'b110, 3'b111};
  // Word forms: addw subw sllw srlw sraw
  localparam logic [2:0] word_f3 [0:4] = '{3'b000, 3'b000, 3'b001, 3'b101, 3'b101};
  // LUI, load, JAL, branch, store, then bad funct7 or funct3 encodings
  localparam logic [31:0] bad_instr [0:9] = '{32'h0000_0037, 32'h0000_0003, 32'h0000_006f,
                                              32'h0000_0063, 32'h0000_0023, 32'h0200_0033,
                                              32'h4000_4033, 32'h0000_203b, 32'h4000_1013,
                                              32'h0000_2067};

  riscv_exec_wb riscv_exec_wb_i (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_wdata),
    .o_wb_dat (wb_rdata),
    .o_wb_ack (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [riscv_isa_pkg::xlen-1:0] ref_alu(
    input riscv_isa_pkg::alu_op_t op,
    input logic [riscv_isa_pkg::xlen-1:0] a,
    input logic [riscv_isa_pkg::xlen-1:0] b
  );
    logic [riscv_isa_pkg::xlen-1:0] r;
    logic [31:0]                    w;
    r = '0;
    w = '0;
    case (op)
      riscv_isa_pkg::alu_add:  r = a + b;
      riscv_isa_pkg::alu_sub:  r = a - b;
      riscv_isa_pkg::alu_sll:  r = a << b[5:0];
      riscv_isa_pkg::alu_slt:  r = {63'd0, $signed(a) < $signed(b)};
      riscv_isa_pkg::alu_sltu: r = {63'd0, a < b};
      riscv_isa_pkg::alu_xor:  r = a ^ b;
      riscv_isa_pkg::alu_srl:  r = a >> b[5:0];
      riscv_isa_pkg::alu_sra:  r = $signed(a) >>> b[5:0];
      riscv_isa_pkg::alu_or:   r = a | b;
      riscv_isa_pkg::alu_and:  r = a & b;
      riscv_isa_pkg::alu_jalr: r = (a + b) & ~64'd1;
      riscv_isa_pkg::alu_addw: w = a[31:0] + b[31:0];
      riscv_isa_pkg::alu_subw: w = a[31:0] - b[31:0];
      riscv_isa_pkg::alu_sllw: w = a[31:0] << b[4:0];
      riscv_isa_pkg::alu_srlw: w = a[31:0] >> b[4:0];
      riscv_isa_pkg::alu_sraw: w = $signed(a[31:0]) >>> b[4:0];
      default:                 r = a + b;
    endcase
    // Word results are sign extended from bit 31
    if (op[4]) begin
      r = {{32{w[31]}}, w};
    end
    return r;
  endfunction

  function automatic riscv_isa_pkg::alu_op_t op_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: begin
        if (alt) begin
          return riscv_isa_pkg::alu_sub;
        end
        return riscv_isa_pkg::alu_add;
      end
      3'b001: return riscv_isa_pkg::alu_sll;
      3'b010: return riscv_isa_pkg::alu_slt;
      3'b011: return riscv_isa_pkg::alu_sltu;
      3'b100: return riscv_isa_pkg::alu_xor;
      3'b101: begin
        if (alt) begin
          return riscv_isa_pkg::alu_sra;
        end
        return riscv_isa_pkg::alu_srl;
      end
      3'b110: return riscv_isa_pkg::alu_or;
      default: return riscv_isa_pkg::alu_and;
    endcase
  endfunction

  // Returns legality, gives the operation and operand source
  function automatic logic ref_decode(input logic [31:0] instr,
                                      output riscv_isa_pkg::alu_op_t op,
                                      output logic use_imm);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    logic       legal;
    f3      = instr[14:12];
    f7      = instr[31:25];
    alt     = (f7 == riscv_isa_pkg::f7_alt);
    op      = riscv_isa_pkg::alu_add;
    use_imm = 1'b0;
    legal   = 1'b0;
    case (instr[6:0])
      riscv_isa_pkg::opc_op: begin
        legal = (f7 == 7'd0) || (alt && (f3 == 3'b000 || f3 == 3'b101));
        op    = op_from_f3(f3, alt);
      end
      riscv_isa_pkg::opc_op_imm: begin
        use_imm = 1'b1;
        // 64-bit shamt takes bit 25, so only bits 31:26 are funct
        alt     = (instr[31:26] == 6'b010000);
        legal   = 1'b1;
        if (f3 == 3'b001) begin
          legal = (instr[31:26] == 6'd0);
        end
        if (f3 == 3'b101) begin
          legal = (instr[31:26] == 6'd0) || alt;
        end
        op = op_from_f3(f3, alt && f3 == 3'b101);
      end
      riscv_isa_pkg::opc_op_32, riscv_isa_pkg::opc_op_imm_32: begin
        use_imm = (instr[6:0] == riscv_isa_pkg::opc_op_imm_32);
        case (f3)
          3'b000: begin
            legal = use_imm || f7 == 7'd0 || alt;
            if (alt && !use_imm) begin
              op = riscv_isa_pkg::alu_subw;
            end else begin
              op = riscv_isa_pkg::alu_addw;
            end
          end
          3'b001: begin
            legal = (f7 == 7'd0);
            op    = riscv_isa_pkg::alu_sllw;
          end
          3'b101: begin
            legal = (f7 == 7'd0) || alt;
            if (alt) begin
              op = riscv_isa_pkg::alu_sraw;
            end else begin
              op = riscv_isa_pkg::alu_srlw;
            end
          end
          default: legal = 1'b0;
        endcase
      end
      riscv_isa_pkg::opc_jalr: begin
        use_imm = 1'b1;
        legal   = (f3 == 3'b000);
        op      = riscv_isa_pkg::alu_jalr;
      end
      default: legal = 1'b0;
    endcase
    return legal;
  endfunction

  // One classic single access, bounded by 20 cycles
  task automatic bus_cycle(input logic we, input logic [riscv_wb_pkg::wb_adr_w-1:0] adr,
                           input logic [riscv_wb_pkg::wb_dat_w-1:0] wdata,
                           output logic [riscv_wb_pkg::wb_dat_w-1:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    while (!wb_ack && waited < 20) begin
      @(posedge clk);
      #1;
      waited++;
    end
    rdata = wb_rdata;
    if (!wb_ack) begin
      $display("Timeout: bus %s at address %0d got no ack within 20 cycles",
               we ? "write" : "read", adr);
      timeouts++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [riscv_wb_pkg::wb_adr_w-1:0] adr,
                          input logic [riscv_wb_pkg::wb_dat_w-1:0] data);
    logic [riscv_wb_pkg::wb_dat_w-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [riscv_wb_pkg::wb_adr_w-1:0] adr,
                         output logic [riscv_wb_pkg::wb_dat_w-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  // Update the model, then send the instruction
  task automatic execute(input logic [31:0] instr);
    riscv_isa_pkg::alu_op_t         op;
    logic                           use_imm;
    logic                           legal;
    logic [riscv_isa_pkg::xlen-1:0] b;
    logic [riscv_isa_pkg::xlen-1:0] res;
    legal = ref_decode(instr, op, use_imm);
    b     = use_imm ? {{52{instr[31]}}, instr[31:20]} : model_regs[instr[24:20]];
    res   = ref_alu(op, model_regs[instr[19:15]], b);
    if (!legal) begin
      if (model_illegal != 8'hff) begin
        model_illegal = model_illegal + 8'd1;
      end
    end else if (op == riscv_isa_pkg::alu_jalr) begin
      model_target = res;
    end else if (instr[11:7] != 5'd0) begin
      model_regs[instr[11:7]] = res;
    end
    wb_write(riscv_wb_pkg::adr_instr, {32'd0, instr});
  endtask

  task automatic check_reg(input string name, input logic [riscv_isa_pkg::xlen-1:0] exp,
                           input logic [riscv_isa_pkg::xlen-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %h actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_count(input string name,
                             input logic [riscv_wb_pkg::illegal_cnt_w-1:0] exp,
                             input logic [riscv_wb_pkg::wb_dat_w-1:0] act);
    if (act !== {{(riscv_wb_pkg::wb_dat_w-riscv_wb_pkg::illegal_cnt_w){1'b0}}, exp}) begin
      $display("Fail %s: expected %0d actual %0d", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_reg_at(input string name, input logic [4:0] idx);
    logic [riscv_wb_pkg::wb_dat_w-1:0] data;
    wb_read(riscv_wb_pkg::adr_reg_base + {1'b0, idx}, data);
    check_reg($sformatf("%s x%0d", name, idx), model_regs[idx], data);
  endtask

  // Every register, the target and the illegal count
  task automatic compare_state(input string name);
    logic [riscv_wb_pkg::wb_dat_w-1:0] data;
    for (int i = 0; i < 32; i++) begin
      check_reg_at(name, 5'(i));
    end
    wb_read(riscv_wb_pkg::adr_target, data);
    check_reg({name, " target"}, model_target, data);
    wb_read(riscv_wb_pkg::adr_illegal, data);
    check_count({name, " illegal count"}, model_illegal, data);
  endtask

  initial begin
    logic [3:0]                        sel;
    logic [2:0]                        wsel;
    logic                              alt;
    logic [2:0]                        f3;
    logic [4:0]                        rd;
    logic [4:0]                        rs1;
    logic [4:0]                        rs2;
    logic [11:0]                       imm;
    logic [31:0]                       instr;
    logic [riscv_wb_pkg::wb_dat_w-1:0] data;
    void'($urandom(77));
    rst           = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_wdata      = '0;
    mismatches    = 0;
    timeouts      = 0;
    model_target  = '0;
    model_illegal = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    compare_state("reset");

    // Wide random values from addi, slli and xori
    for (int r = 1; r < 32; r++) begin
      execute(i_type(12'($urandom), 5'd0, riscv_isa_pkg::f3_add_sub, 5'(r),
                     riscv_isa_pkg::opc_op_imm));
      execute(i_type({6'd0, 6'($urandom)}, 5'(r), riscv_isa_pkg::f3_sll, 5'(r),
                     riscv_isa_pkg::opc_op_imm));
      execute(i_type(12'($urandom), 5'(r), riscv_isa_pkg::f3_xor, 5'(r),
                     riscv_isa_pkg::opc_op_imm));
    end
    compare_state("load");

    for (int n = 0; n < 200; n++) begin
      sel = 4'($urandom_range(0, 9));
      alt = (sel == 4'd1) || (sel == 4'd7);
      f3  = op_f3[sel];
      rd  = 5'($urandom_range(1, 31));
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      if (sel != 4'd1 && $urandom_range(0, 1) == 1) begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm = {1'b0, alt, 4'd0, 6'($urandom)};
        end else begin
          imm = 12'($urandom);
        end
        instr = i_type(imm, rs1, f3, rd, riscv_isa_pkg::opc_op_imm);
      end else begin
        instr = r_type(alt ? riscv_isa_pkg::f7_alt : 7'd0, rs2, rs1, f3, rd,
                       riscv_isa_pkg::opc_op);
      end
      execute(instr);
      check_reg_at("op", rd);
    end

    for (int n = 0; n < 100; n++) begin
      wsel = 3'($urandom_range(0, 4));
      alt  = (wsel == 3'd1) || (wsel == 3'd4);
      f3   = word_f3[wsel];
      rd   = 5'($urandom_range(1, 31));
      rs1  = 5'($urandom);
      rs2  = 5'($urandom);
      if (wsel != 3'd1 && $urandom_range(0, 1) == 1) begin
        if (wsel == 3'd0) begin
          imm = 12'($urandom);
        end else begin
          imm = {1'b0, alt, 5'd0, 5'($urandom)};
        end
        instr = i_type(imm, rs1, f3, rd, riscv_isa_pkg::opc_op_imm_32);
      end else begin
        instr = r_type(alt ? riscv_isa_pkg::f7_alt : 7'd0, rs2, rs1, f3, rd,
                       riscv_isa_pkg::opc_op_32);
      end
      execute(instr);
      check_reg_at("word", rd);
    end
    compare_state("word");

    // JALR with a nonzero rd must not write a link value
    for (int n = 0; n < 20; n++) begin
      execute(i_type(12'($urandom), 5'($urandom), 3'b000, 5'($urandom_range(1, 31)),
                     riscv_isa_pkg::opc_jalr));
      wb_read(riscv_wb_pkg::adr_target, data);
      check_reg("jalr target", model_target, data);
    end
    compare_state("jalr");

    execute(i_type(12'($urandom), 5'd1, riscv_isa_pkg::f3_add_sub, 5'd0,
                   riscv_isa_pkg::opc_op_imm));
    execute(r_type(7'd0, 5'd2, 5'd3, riscv_isa_pkg::f3_or, 5'd0, riscv_isa_pkg::opc_op));
    check_reg_at("x0 write", 5'd0);

    // rd and rs1 fields do not affect legality
    for (int k = 0; k < 10; k++) begin
      execute(bad_instr[4'(k)] | {12'd0, 5'($urandom), 3'd0, 5'($urandom), 7'd0});
      wb_read(riscv_wb_pkg::adr_illegal, data);
      check_count("illegal", model_illegal, data);
    end
    compare_state("illegal");

    // Push the counter past its limit
    for (int k = 0; k < 260; k++) begin
      execute(bad_instr[4'($urandom_range(0, 9))]);
    end
    wb_read(riscv_wb_pkg::adr_illegal, data);
    check_count("saturate", model_illegal, data);

    wb_write(riscv_wb_pkg::adr_target, {$urandom, $urandom});
    compare_state("ignored write");

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* riscv_exec_wb.f */
rtl/riscv_isa_pkg.sv
rtl/riscv_wb_pkg.sv
rtl/riscv_alu_if.sv
rtl/riscv_alu.sv
rtl/riscv_decoder.sv
rtl/riscv_regfile.sv
rtl/riscv_exec_wb.sv
sim/riscv_exec_wb_sva.sv
sim/riscv_exec_wb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the RV64I execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f riscv_exec_wb.f \
  --top-module riscv_exec_wb_tb -o riscv_exec_wb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/riscv_exec_wb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q -F '*** PASSED ***' "$SIM_LOG"; then
  exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1
